// File: alu.sv
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    localparam int HALF = WORD_WIDTH / 2;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_NOT:    result = ~a;
            ALU_TCP:    result = ~a + 1'b1;                            // negate
            ALU_SHL:    result = {a[WORD_WIDTH-2:0], 1'b0};
            ALU_SHR:    result = {a[WORD_WIDTH-1], a[WORD_WIDTH-1:1]}; // keeps sign
            ALU_PASS_B: result = b;
            ALU_LHI:    result = {b[HALF-1:0], {HALF{1'b0}}};
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: branch_unit.sv
`default_nettype none

module branch_unit import cpu_pkg::*; (
    input  branch_kind_e kind,
    input  word_t        a,
    input  word_t        b,
    input  word_t        pc,
    input  word_t        inst,
    output logic         redirect,
    output word_t        target
);

    word_t br_target;
    word_t jmp_target;

    assign br_target  = pc + 1'b1 + sext_imm(inst);
    assign jmp_target = {pc[WORD_WIDTH-1:TARGET_HI+1], inst[TARGET_HI:TARGET_LO]};

    // fetch always guesses pc + 1, so only taken ones redirect
    always_comb begin
        redirect = 1'b0;
        target   = br_target;
        case (kind)
            BR_NE: redirect = (a != b);
            BR_EQ: redirect = (a == b);
            BR_GZ: redirect = ($signed(a) > 0);
            BR_LZ: redirect = a[WORD_WIDTH-1];
            BR_JUMP: begin
                redirect = 1'b1;
                target   = jmp_target;
            end
            BR_REG: begin
                redirect = 1'b1;
                target   = a;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: control_unit.sv
`default_nettype none

module control_unit import cpu_pkg::*; (
    input  word_t        inst,
    output alu_op_e      alu_op,
    output logic         alu_src_imm,
    output logic         mem_read,
    output logic         mem_write,
    output logic         reg_write,
    output wr_dest_e     write_dest,
    output logic         pc_to_reg,
    output branch_kind_e branch_kind,
    output logic         is_wwd,
    output logic         is_halt
);

    opcode_e op;
    funct_e  fn;

    assign op = opcode_e'(inst[OP_HI:OP_LO]);
    assign fn = funct_e'(inst[FUNC_HI:FUNC_LO]);

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_write   = 1'b0;
        write_dest  = DEST_RT;
        pc_to_reg   = 1'b0;
        branch_kind = BR_NONE;
        is_wwd      = 1'b0;
        is_halt     = 1'b0;

        case (op)
            OP_BNE: branch_kind = BR_NE;
            OP_BEQ: branch_kind = BR_EQ;
            OP_BGZ: branch_kind = BR_GZ;
            OP_BLZ: branch_kind = BR_LZ;
            OP_ADI, OP_ORI, OP_LHI, OP_LWD: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                mem_read    = (op == OP_LWD);
                if (op == OP_ORI) begin
                    alu_op = ALU_OR;
                end else if (op == OP_LHI) begin
                    alu_op = ALU_LHI;
                end
            end
            OP_SWD: begin
                alu_src_imm = 1'b1;      // address = rs + imm
                mem_write   = 1'b1;
            end
            OP_JMP: branch_kind = BR_JUMP;
            OP_JAL: begin
                branch_kind = BR_JUMP;
                reg_write   = 1'b1;
                write_dest  = DEST_LINK;
                pc_to_reg   = 1'b1;
            end
            OP_RTYPE: begin
                write_dest = DEST_RD;
                case (fn)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR,
                    FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                        reg_write = 1'b1;
                        alu_op    = alu_op_e'(fn[3:0]);  // same order as alu_op_e
                    end
                    FN_JPR: branch_kind = BR_REG;
                    FN_JRL: begin
                        branch_kind = BR_REG;
                        reg_write   = 1'b1;
                        write_dest  = DEST_LINK;
                        pc_to_reg   = 1'b1;
                    end
                    FN_WWD:  is_wwd = 1'b1;
                    FN_HLT:  is_halt = 1'b1;
                    default: ;
                endcase
            end
            default: ;               // unknown opcode runs as a nop
        endcase
    end

endmodule

`default_nettype wire

// File: cpu.sv
`default_nettype none

module cpu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    output word_t i_addr,
    input  word_t i_data,
    output logic  d_read,
    output logic  d_write,
    output word_t d_addr,
    output word_t d_wdata,
    input  word_t d_rdata,
    input  logic  d_ready,
    output word_t output_port,
    output word_t num_inst,
    output logic  is_halted
);

    word_t pc;
    logic  advance;      // low on memory hold or after halt
    logic  stall;
    logic  br_redirect;
    logic  take_branch;
    word_t br_target;

    // if/id
    logic  if_id_valid;
    word_t if_id_inst;
    word_t if_id_pc;

    // id/ex
    logic     id_ex_valid;
    word_t    id_ex_pc;
    word_t    id_ex_a;
    word_t    id_ex_b;
    word_t    id_ex_imm;
    reg_idx_t id_ex_rs;
    reg_idx_t id_ex_rt;
    reg_idx_t id_ex_dest;
    alu_op_e  id_ex_alu_op;
    logic     id_ex_alu_src_imm;
    logic     id_ex_mem_read;
    logic     id_ex_mem_write;
    logic     id_ex_reg_write;
    logic     id_ex_pc_to_reg;
    logic     id_ex_is_wwd;
    logic     id_ex_is_halt;

    // ex/mem
    logic     ex_mem_valid;
    word_t    ex_mem_result;
    word_t    ex_mem_store;
    reg_idx_t ex_mem_dest;
    logic     ex_mem_mem_read;
    logic     ex_mem_mem_write;
    logic     ex_mem_reg_write;
    logic     ex_mem_is_wwd;
    logic     ex_mem_is_halt;

    // mem/wb
    logic     mem_wb_valid;
    word_t    mem_wb_result;
    reg_idx_t mem_wb_dest;
    logic     mem_wb_reg_write;

    // decode
    alu_op_e      ctl_alu_op;
    logic         ctl_alu_src_imm;
    logic         ctl_mem_read;
    logic         ctl_mem_write;
    logic         ctl_reg_write;
    wr_dest_e     ctl_write_dest;
    logic         ctl_pc_to_reg;
    branch_kind_e ctl_branch_kind;
    logic         ctl_is_wwd;
    logic         ctl_is_halt;

    reg_idx_t id_rs;
    reg_idx_t id_rt;
    reg_idx_t id_dest;
    word_t    id_imm;
    word_t    rf_a;
    word_t    rf_b;
    word_t    br_a;
    word_t    br_b;
    fwd_sel_e fwd_id_a;
    fwd_sel_e fwd_id_b;
    fwd_sel_e fwd_ex_a;
    fwd_sel_e fwd_ex_b;
    word_t    ex_a;
    word_t    ex_b;
    word_t    alu_out;
    word_t    ex_result;
    word_t    mem_result;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t own,
                                      input word_t near_val, input word_t far_val);
        case (sel)
            FWD_MEM: return near_val;
            FWD_WB:  return far_val;
            default: return own;
        endcase
    endfunction

    assign advance = d_ready && !is_halted;
    assign i_addr  = pc;

    //////////////////////////////////////////////////////////////////////
    // ID

    assign id_rs = if_id_inst[RS_HI:RS_LO];
    assign id_rt = if_id_inst[RT_HI:RT_LO];

    always_comb begin
        case (ctl_write_dest)
            DEST_RT:   id_dest = id_rt;
            DEST_LINK: id_dest = LINK_REG;
            default:   id_dest = if_id_inst[RD_HI:RD_LO];
        endcase
    end

    assign id_imm = (opcode_e'(if_id_inst[OP_HI:OP_LO]) == OP_ORI) ?
                    zext_imm(if_id_inst) : sext_imm(if_id_inst);

    control_unit u_control (
        .inst(if_id_inst), .alu_op(ctl_alu_op), .alu_src_imm(ctl_alu_src_imm),
        .mem_read(ctl_mem_read), .mem_write(ctl_mem_write), .reg_write(ctl_reg_write),
        .write_dest(ctl_write_dest), .pc_to_reg(ctl_pc_to_reg),
        .branch_kind(ctl_branch_kind), .is_wwd(ctl_is_wwd), .is_halt(ctl_is_halt)
    );

    register_file u_regs (
        .clk(clk), .reset_n(reset_n), .read_idx1(id_rs), .read_idx2(id_rt),
        .write_idx(mem_wb_dest), .write_data(mem_wb_result),
        .write_en(mem_wb_valid && mem_wb_reg_write),
        .read_data1(rf_a), .read_data2(rf_b)
    );

    // a load counts as a writer too
    hazard_detect u_hazard (
        .if_id_inst(if_id_inst), .if_id_valid(if_id_valid),
        .id_ex_mem_read(id_ex_mem_read), .id_ex_dest(id_ex_dest),
        .id_ex_valid(id_ex_valid && id_ex_reg_write), .stall(stall)
    );

    forwarding_unit fwd_id (
        .src_a(id_rs), .src_b(id_rt),
        .near_write(id_ex_valid && id_ex_reg_write), .near_dest(id_ex_dest),
        .far_write(ex_mem_valid && ex_mem_reg_write), .far_dest(ex_mem_dest),
        .fwd_a(fwd_id_a), .fwd_b(fwd_id_b)
    );

    assign br_a = fwd_mux(fwd_id_a, rf_a, ex_result, mem_result);
    assign br_b = fwd_mux(fwd_id_b, rf_b, ex_result, mem_result);

    branch_unit u_branch (
        .kind(ctl_branch_kind), .a(br_a), .b(br_b), .pc(if_id_pc), .inst(if_id_inst),
        .redirect(br_redirect), .target(br_target)
    );

    assign take_branch = if_id_valid && br_redirect && !stall;

    //////////////////////////////////////////////////////////////////////
    // EX

    forwarding_unit fwd_ex (
        .src_a(id_ex_rs), .src_b(id_ex_rt),
        .near_write(ex_mem_valid && ex_mem_reg_write), .near_dest(ex_mem_dest),
        .far_write(mem_wb_valid && mem_wb_reg_write), .far_dest(mem_wb_dest),
        .fwd_a(fwd_ex_a), .fwd_b(fwd_ex_b)
    );

    assign ex_a = fwd_mux(fwd_ex_a, id_ex_a, mem_result, mem_wb_result);
    assign ex_b = fwd_mux(fwd_ex_b, id_ex_b, mem_result, mem_wb_result);

    alu u_alu (
        .op(id_ex_alu_op), .a(ex_a), .b(id_ex_alu_src_imm ? id_ex_imm : ex_b), .result(alu_out)
    );

    // link and wwd values ride the result path
    assign ex_result = id_ex_pc_to_reg ? id_ex_pc + 1'b1 :
                       id_ex_is_wwd    ? ex_a : alu_out;

    //////////////////////////////////////////////////////////////////////
    // MEM

    assign d_read     = ex_mem_valid && ex_mem_mem_read && !is_halted;
    assign d_write    = ex_mem_valid && ex_mem_mem_write && !is_halted;
    assign d_addr     = ex_mem_result;
    assign d_wdata    = ex_mem_store;
    assign mem_result = ex_mem_mem_read ? d_rdata : ex_mem_result;

    //////////////////////////////////////////////////////////////////////
    // pipeline registers

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc           <= '0;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
            num_inst     <= '0;
            output_port  <= '0;
            is_halted    <= 1'b0;
        end else if (advance) begin
            if (take_branch) begin
                pc <= br_target;
            end else if (!stall) begin
                pc <= pc + 1'b1;
            end
            if (!stall) begin
                if_id_valid <= !take_branch;   // drop the slot after a redirect
            end
            id_ex_valid  <= if_id_valid && !stall;
            ex_mem_valid <= id_ex_valid;
            mem_wb_valid <= ex_mem_valid;
            if (ex_mem_valid) begin
                num_inst <= num_inst + 1'b1;
                if (ex_mem_is_wwd) output_port <= mem_result;
                if (ex_mem_is_halt) is_halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (!stall) begin
                if_id_inst <= i_data;
                if_id_pc   <= pc;
            end
            id_ex_pc          <= if_id_pc;
            id_ex_a           <= rf_a;
            id_ex_b           <= rf_b;
            id_ex_imm         <= id_imm;
            id_ex_rs          <= id_rs;
            id_ex_rt          <= id_rt;
            id_ex_dest        <= id_dest;
            id_ex_alu_op      <= ctl_alu_op;
            id_ex_alu_src_imm <= ctl_alu_src_imm;
            id_ex_mem_read    <= ctl_mem_read;
            id_ex_mem_write   <= ctl_mem_write;
            id_ex_reg_write   <= ctl_reg_write;
            id_ex_pc_to_reg   <= ctl_pc_to_reg;
            id_ex_is_wwd      <= ctl_is_wwd;
            id_ex_is_halt     <= ctl_is_halt;

            ex_mem_result    <= ex_result;
            ex_mem_store     <= ex_b;
            ex_mem_dest      <= id_ex_dest;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_is_wwd    <= id_ex_is_wwd;
            ex_mem_is_halt   <= id_ex_is_halt;

            mem_wb_result    <= mem_result;
            mem_wb_dest      <= ex_mem_dest;
            mem_wb_reg_write <= ex_mem_reg_write;
        end
    end

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_WIDTH     = 16;
    localparam int REG_ADDR_WIDTH = 2;
    localparam int NUM_REGS       = 4;

    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_idx_t;

    localparam reg_idx_t LINK_REG = 2'd2;  // jal / jrl write here

    // instruction field positions
    localparam int OP_HI     = 15;
    localparam int OP_LO     = 12;
    localparam int RS_HI     = 11;
    localparam int RS_LO     = 10;
    localparam int RT_HI     = 9;
    localparam int RT_LO     = 8;
    localparam int RD_HI     = 7;
    localparam int RD_LO     = 6;
    localparam int FUNC_HI   = 5;
    localparam int FUNC_LO   = 0;
    localparam int IMM_HI    = 7;
    localparam int IMM_LO    = 0;
    localparam int TARGET_HI = 11;
    localparam int TARGET_LO = 0;

    typedef enum logic [3:0] {
        OP_BNE = 4'd0, OP_BEQ = 4'd1, OP_BGZ = 4'd2, OP_BLZ = 4'd3,
        OP_ADI = 4'd4, OP_ORI = 4'd5, OP_LHI = 4'd6, OP_LWD = 4'd7,
        OP_SWD = 4'd8, OP_JMP = 4'd9, OP_JAL = 4'd10, OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0, FN_SUB = 6'd1, FN_AND = 6'd2, FN_ORR = 6'd3,
        FN_NOT = 6'd4, FN_TCP = 6'd5, FN_SHL = 6'd6, FN_SHR = 6'd7,
        FN_JPR = 6'd25, FN_JRL = 6'd26, FN_WWD = 6'd28, FN_HLT = 6'd29
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT,
        ALU_TCP, ALU_SHL, ALU_SHR, ALU_PASS_B, ALU_LHI
    } alu_op_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_NE, BR_EQ, BR_GZ, BR_LZ, BR_JUMP, BR_REG
    } branch_kind_e;

    typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_LINK} wr_dest_e;

    function automatic word_t sext_imm(input word_t inst);
        return {{(WORD_WIDTH-IMM_HI-1){inst[IMM_HI]}}, inst[IMM_HI:IMM_LO]};
    endfunction

    function automatic word_t zext_imm(input word_t inst);
        return {{(WORD_WIDTH-IMM_HI-1){1'b0}}, inst[IMM_HI:IMM_LO]};
    endfunction

endpackage

`default_nettype wire

// File: filelist.f
cpu_pkg.sv
alu.sv
register_file.sv
control_unit.sv
forwarding_unit.sv
hazard_detect.sv
branch_unit.sv
cpu.sv
tb_cpu.sv

// File: forwarding_unit.sv
`default_nettype none

module forwarding_unit import cpu_pkg::*; (
    input  reg_idx_t src_a,
    input  reg_idx_t src_b,
    input  logic     near_write,
    input  reg_idx_t near_dest,
    input  logic     far_write,
    input  reg_idx_t far_dest,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b
);

    // nearer stage holds the younger value, so it wins
    function automatic fwd_sel_e pick(input reg_idx_t src);
        if (near_write && near_dest == src) begin
            return FWD_MEM;
        end else if (far_write && far_dest == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a = pick(src_a);
    assign fwd_b = pick(src_b);

endmodule

`default_nettype wire

// File: hazard_detect.sv
`default_nettype none

module hazard_detect import cpu_pkg::*; (
    input  word_t    if_id_inst,
    input  logic     if_id_valid,
    input  logic     id_ex_mem_read,
    input  reg_idx_t id_ex_dest,
    input  logic     id_ex_valid,
    output logic     stall
);

    opcode_e op;
    funct_e  fn;
    logic    is_rtype;
    logic    uses_rs;
    logic    uses_rt;
    logic    is_branch;
    logic    dep;

    assign op       = opcode_e'(if_id_inst[OP_HI:OP_LO]);
    assign fn       = funct_e'(if_id_inst[FUNC_HI:FUNC_LO]);
    assign is_rtype = (op == OP_RTYPE);

    assign uses_rs = !(op inside {OP_JMP, OP_JAL, OP_LHI}) && !(is_rtype && fn == FN_HLT);
    assign uses_rt = (op inside {OP_BNE, OP_BEQ, OP_SWD}) ||
                     (is_rtype && fn inside {FN_ADD, FN_SUB, FN_AND, FN_ORR});

    // compare in id cannot take a value still in the alu
    assign is_branch = (op inside {OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ}) ||
                       (is_rtype && fn inside {FN_JPR, FN_JRL});

    assign dep = (uses_rs && if_id_inst[RS_HI:RS_LO] == id_ex_dest) ||
                 (uses_rt && if_id_inst[RT_HI:RT_LO] == id_ex_dest);

    assign stall = if_id_valid && id_ex_valid && dep && (id_ex_mem_read || is_branch);

endmodule

`default_nettype wire

// File: register_file.sv
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t read_idx1,
    input  reg_idx_t read_idx2,
    input  reg_idx_t write_idx,
    input  word_t    write_data,
    input  logic     write_en,
    output word_t    read_data1,
    output word_t    read_data2
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_idx] <= write_data;
        end
    end

    // write-through, so wb -> id needs no forwarding path
    assign read_data1 = (write_en && write_idx == read_idx1) ? write_data : regs[read_idx1];
    assign read_data2 = (write_en && write_idx == read_idx2) ? write_data : regs[read_idx2];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the cpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_cpu -o sim_cpu

# the simulator may exit nonzero on failure, the log decides
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// File: tb_cpu.sv
`default_nettype none

module tb_cpu import cpu_pkg::*;;

    localparam int    PROG_LEN     = 76;
    localparam int    NUM_OUTS     = 21;
    localparam int    NUM_MEMCHK   = 3;
    localparam int    WAIT_LIMIT   = 300;
    localparam word_t EXP_NUM_INST = 16'd62;  // 59 up to the jmp, minus 4 flushed, plus 7
    localparam word_t POISON       = 16'h407F;  // adi into r0 spoils every later result

    logic  clk;
    logic  reset_n;
    word_t i_addr;
    word_t i_data;
    logic  d_read;
    logic  d_write;
    word_t d_addr;
    word_t d_wdata;
    word_t d_rdata;
    logic  d_ready;
    word_t output_port;
    word_t num_inst;
    logic  is_halted;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       prog [PROG_LEN];
    logic [31:0] lfsr;

    // wwd values in retirement order
    word_t expected_out [NUM_OUTS] = '{
        16'h000D, 16'h0003, 16'h0000, 16'h000D, 16'hFFFA, 16'hFFFB, 16'h0010,
        16'h00F0, 16'hC080, 16'hFFFE, 16'h0010, 16'h0011, 16'h0022, 16'h0033,
        16'h0044, 16'h0055, 16'h0066, 16'h0077, 16'h0018, 16'h003D, 16'h0040
    };
    int    memchk_addr [NUM_MEMCHK] = '{8'h41, 8'h42, 8'h43};
    word_t memchk_data [NUM_MEMCHK];

    cpu uut (
        .clk(clk), .reset_n(reset_n), .i_addr(i_addr), .i_data(i_data),
        .d_read(d_read), .d_write(d_write), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_rdata(d_rdata), .d_ready(d_ready), .output_port(output_port),
        .num_inst(num_inst), .is_halted(is_halted)
    );

    //////////////////////////////////////////////////////////////////////
    // encoders and models

    function automatic word_t itype(input opcode_e op, input int rs, input int rt, input int imm);
        return {op, 2'(rs), 2'(rt), 8'(imm)};
    endfunction

    function automatic word_t rtype(input int rs, input int rt, input int rd, input funct_e fn);
        return {OP_RTYPE, 2'(rs), 2'(rt), 2'(rd), fn};
    endfunction

    function automatic word_t jtype(input opcode_e op, input int target);
        return {op, 12'(target)};
    endfunction

    function automatic word_t dmem_fill(input int addr);
        return 16'hC3A5 ^ {8'(addr), ~8'(addr)};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    assign i_data  = imem[i_addr[7:0]];
    // only a ready read returns real data
    assign d_rdata = (d_read && d_ready) ? dmem[d_addr[7:0]] : 16'hDEAD;

    always @(posedge clk) begin
        if (d_write && d_ready) begin
            dmem[d_addr[7:0]] <= d_wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reporting

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic wait_output_change(input word_t prev);
        int cycles;
        cycles = 0;
        while (output_port === prev) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("output_port did not change in time");
            end
        end
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        while (is_halted !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("is_halted never rose");
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock and random back-pressure

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        lfsr    = 32'h8ad097e7;
        d_ready = 1'b0;
        forever begin
            @(negedge clk);
            lfsr    = lfsr_step(lfsr);
            d_ready = lfsr[0];
        end
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= dmem_fill(i);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        word_t prev;
        reset_n = 1'b1;
        prog = '{
            itype(OP_ADI, 0, 1, 5), itype(OP_ADI, 1, 2, 3), rtype(1, 2, 3, FN_ADD),
            rtype(3, 0, 0, FN_WWD), rtype(2, 1, 3, FN_SUB), rtype(3, 0, 0, FN_WWD),
            rtype(1, 2, 3, FN_AND), rtype(3, 0, 0, FN_WWD), rtype(1, 2, 3, FN_ORR),
            rtype(3, 0, 0, FN_WWD), rtype(1, 0, 3, FN_NOT), rtype(3, 0, 0, FN_WWD),
            rtype(1, 0, 3, FN_TCP), rtype(3, 0, 0, FN_WWD), rtype(2, 0, 3, FN_SHL),
            rtype(3, 0, 0, FN_WWD), itype(OP_ORI, 0, 3, 'hF0), rtype(3, 0, 0, FN_WWD),
            itype(OP_LHI, 0, 3, 'h81), rtype(3, 0, 3, FN_SHR), rtype(3, 0, 0, FN_WWD),
            itype(OP_ADI, 0, 3, 'hFE), rtype(3, 0, 0, FN_WWD),
            // load / store at 0x41 and 0x42
            itype(OP_ADI, 0, 1, 'h40), itype(OP_SWD, 1, 2, 1), itype(OP_LWD, 1, 3, 1),
            rtype(3, 3, 3, FN_ADD), rtype(3, 0, 0, FN_WWD), itype(OP_SWD, 1, 3, 2),
            // branches with poison in each flushed slot
            itype(OP_BNE, 1, 2, 1), POISON, itype(OP_ADI, 0, 3, 'h11),
            rtype(3, 0, 0, FN_WWD), itype(OP_BEQ, 1, 2, 1), itype(OP_ADI, 0, 3, 'h22),
            rtype(3, 0, 0, FN_WWD), itype(OP_BEQ, 0, 0, 1), POISON,
            itype(OP_ADI, 0, 3, 'h33), rtype(3, 0, 0, FN_WWD), itype(OP_BGZ, 1, 0, 1),
            POISON, itype(OP_ADI, 0, 3, 'h44), rtype(3, 0, 0, FN_WWD),
            itype(OP_BGZ, 0, 0, 1), itype(OP_ADI, 0, 3, 'h55), rtype(3, 0, 0, FN_WWD),
            itype(OP_ADI, 0, 2, 'hFD), itype(OP_BLZ, 2, 0, 1), POISON,
            itype(OP_ADI, 0, 3, 'h66), rtype(3, 0, 0, FN_WWD), itype(OP_BLZ, 1, 0, 1),
            itype(OP_ADI, 0, 3, 'h77), rtype(3, 0, 0, FN_WWD), itype(OP_BNE, 0, 0, 1),
            itype(OP_ADI, 0, 3, 'h18), rtype(3, 0, 0, FN_WWD),
            // jump chain 58 -> 60 -> 70 -> 61 then 63 -> 74
            jtype(OP_JMP, 60), POISON, jtype(OP_JAL, 70), rtype(2, 0, 0, FN_WWD),
            itype(OP_ADI, 0, 1, 74), rtype(1, 0, 0, FN_JRL),
            POISON, POISON, POISON, POISON, POISON, POISON,
            rtype(2, 0, 0, FN_JPR), POISON, POISON, POISON,
            rtype(2, 0, 0, FN_WWD), rtype(0, 0, 0, FN_HLT)
        };
        for (int i = 0; i < 256; i++) begin
            imem[i] = itype(OP_ADI, 0, 3, i);  // stray fetches load r3 with their address
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = prog[i];
        end
        memchk_data[0] = 16'h0008;
        memchk_data[1] = 16'h0010;
        memchk_data[2] = dmem_fill(8'h43);

        repeat (16) @(negedge clk);
        reset_n = 1'b0;

        prev = output_port;
        for (int i = 0; i < NUM_OUTS; i++) begin
            wait_output_change(prev);
            check_word(output_port, expected_out[i], $sformatf("output_port #%0d", i));
            prev = output_port;
        end

        wait_halt();
        check_flag(is_halted, 1'b1, "is_halted");
        check_word(num_inst, EXP_NUM_INST, "num_inst");
        repeat (20) begin
            @(negedge clk);
            check_flag(is_halted, 1'b1, "is_halted after halt");
            check_word(num_inst, EXP_NUM_INST, "num_inst after halt");
            check_word(output_port, prev, "output_port after halt");
        end

        for (int i = 0; i < NUM_MEMCHK; i++) begin
            check_word(dmem[memchk_addr[i]], memchk_data[i],
                       $sformatf("dmem[%h]", memchk_addr[i]));
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
